// ==== include/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clocks per bit out of reset
`define UART_BAUD_DEFAULT 16'd54

// entries in each of the tx and rx FIFOs
`define UART_FIFO_DEPTH 16

// register offset width on the host bus
`define UART_ADDR_W 2

// register map
`define UART_REG_TX     0     // wr: push tx byte, rd: rx status and head
`define UART_REG_RX_POP 1     // wr: pop rx FIFO
`define UART_REG_BAUD   2     // rd/wr: clocks per bit

`endif

// ==== design/uart_pkg.sv ====
`include "uart_consts.svh"

package uart_pkg;

   typedef logic [7:0]              byte_t;
   typedef logic [15:0]             baud_t;
   typedef logic [8:0]              rx_entry_t;      // {framing error, byte}
   typedef logic [`UART_ADDR_W-1:0] reg_addr_t;

   // one host access, qualified by en
   typedef struct packed {
      logic        en;
      logic        we;
      reg_addr_t   addr;
      logic [31:0] wdata;
   } bus_req_t;

   // read word of offset 0, zero-extended on the bus
   typedef struct packed {
      logic      rx_full;
      logic      tx_full;
      logic      rx_empty;
      rx_entry_t head;
   } rx_status_t;

   typedef enum logic [2:0] {
      UTX_IDLE,
      UTX_EMPTY,
      UTX_POP,
      UTX_START,
      UTX_INUSE
   } utx_state_t;

   typedef enum logic [1:0] {
      URX_IDLE,
      URX_START,
      URX_DATA,
      URX_STOP
   } urx_state_t;

endpackage

// ==== design/uart_regs.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_regs
(
   input  logic                 msoc_clk,
   input  logic                 rstn,
   input  uart_pkg::bus_req_t   bus_i,
   input  uart_pkg::rx_entry_t  rx_head_i,
   input  logic                 rx_empty_i,
   input  logic                 rx_full_i,
   input  logic                 tx_full_i,
   output logic [31:0]          rdata_o,
   output logic                 tx_push_o,
   output uart_pkg::byte_t      tx_byte_o,
   output logic                 rx_pop_o,
   output uart_pkg::baud_t      baud_o
);

   logic                 wr_stb;
   logic                 rd_stb;
   uart_pkg::rx_status_t status;
   logic [31:0]          rd_word;

   assign wr_stb = bus_i.en & bus_i.we;
   assign rd_stb = bus_i.en & ~bus_i.we;

   always_comb
   begin
      status.rx_full  = rx_full_i;
      status.tx_full  = tx_full_i;
      status.rx_empty = rx_empty_i;
      status.head     = rx_head_i;
   end

   always_comb
   begin
      case (bus_i.addr)
         `UART_REG_TX:   rd_word = {20'd0, status};
         `UART_REG_BAUD: rd_word = {16'd0, baud_o};
         default:        rd_word = 32'd0;      // pop register reads as zero
      endcase
   end

   // strobes last exactly one cycle, baud is a level
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_push_o <= 1'b0;
         rx_pop_o  <= 1'b0;
         baud_o    <= `UART_BAUD_DEFAULT;
      end
      else
      begin
         tx_push_o <= wr_stb && (bus_i.addr == `UART_REG_TX);
         rx_pop_o  <= wr_stb && (bus_i.addr == `UART_REG_RX_POP);
         if (wr_stb && (bus_i.addr == `UART_REG_BAUD))
         begin
            baud_o <= bus_i.wdata[15:0];
         end
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (wr_stb && (bus_i.addr == `UART_REG_TX))
      begin
         tx_byte_o <= bus_i.wdata[7:0];      // valid alongside tx_push_o
      end
      if (rd_stb)
      begin
         rdata_o <= rd_word;                 // held until the next read
      end
   end

   // engines need at least one clock per bit
   a_baud_nonzero: assert property (@(posedge msoc_clk) disable iff (!rstn)
      baud_o != '0);

endmodule

// ==== design/uart_fifo.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_fifo
#(
   parameter int WIDTH = 8
)
(
   input  logic             msoc_clk,
   input  logic             rstn,
   input  logic             push_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] data_o,
   output logic             full_o,
   output logic             empty_o
);

   localparam int DEPTH = `UART_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i & ~full_o;      // overflow is dropped
   assign do_pop  = pop_i & ~empty_o;

   assign full_o  = (count == DEPTH[AW:0]);
   assign empty_o = (count == '0);
   assign data_o  = mem[rd_ptr];           // head shown combinationally

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;      // wraps at DEPTH
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   // occupancy stays within the buffer
   a_count_range: assert property (@(posedge msoc_clk) disable iff (!rstn)
      count <= DEPTH[AW:0]);

endmodule

// ==== design/uart_tx_engine.sv ====
`timescale 1ns/1ps

module uart_tx_engine
(
   input  logic             msoc_clk,
   input  logic             rstn,
   input  uart_pkg::baud_t  baud_i,
   input  logic             fifo_empty_i,
   input  uart_pkg::byte_t  fifo_data_i,
   output logic             fifo_pop_o,
   output logic             tx_o
);

   uart_pkg::utx_state_t state_q;
   uart_pkg::utx_state_t state_d;
   uart_pkg::baud_t      baud_cnt;
   logic [3:0]           bit_cnt;      // 0 start, 1..8 data, 9 stop
   logic [8:0]           shreg;        // stop bit above the data byte
   logic                 bit_end;
   logic                 frame_done;

   assign bit_end    = (baud_cnt == '0);
   assign frame_done = bit_end && (bit_cnt == 4'd9);
   assign fifo_pop_o = (state_q == uart_pkg::UTX_POP);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         uart_pkg::UTX_IDLE:  state_d = uart_pkg::UTX_EMPTY;
         uart_pkg::UTX_EMPTY:
         begin
            if (!fifo_empty_i)
            begin
               state_d = uart_pkg::UTX_POP;
            end
         end
         uart_pkg::UTX_POP:   state_d = uart_pkg::UTX_START;
         uart_pkg::UTX_START: state_d = uart_pkg::UTX_INUSE;
         uart_pkg::UTX_INUSE:
         begin
            if (frame_done)
            begin
               state_d = uart_pkg::UTX_IDLE;
            end
         end
         default:             state_d = uart_pkg::UTX_IDLE;
      endcase
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q  <= uart_pkg::UTX_IDLE;
         tx_o     <= 1'b1;      // line idles high
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == uart_pkg::UTX_START)
         begin
            tx_o     <= 1'b0;      // start bit
            baud_cnt <= baud_i - 16'd1;
            bit_cnt  <= '0;
         end
         else if ((state_q == uart_pkg::UTX_INUSE) && !frame_done)
         begin
            if (bit_end)
            begin
               tx_o     <= shreg[0];
               baud_cnt <= baud_i - 16'd1;
               bit_cnt  <= bit_cnt + 4'd1;
            end
            else
            begin
               baud_cnt <= baud_cnt - 16'd1;
            end
         end
      end
   end

   // byte is taken as the pop lands, head moves on after that
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == uart_pkg::UTX_POP)
      begin
         shreg <= {1'b1, fifo_data_i};
      end
      else if ((state_q == uart_pkg::UTX_INUSE) && bit_end)
      begin
         shreg <= {1'b1, shreg[8:1]};      // lsb first
      end
   end

   a_pop_not_empty: assert property (@(posedge msoc_clk) disable iff (!rstn)
      fifo_pop_o |-> !fifo_empty_i);

endmodule

// ==== design/uart_rx_engine.sv ====
`timescale 1ns/1ps

module uart_rx_engine
(
   input  logic                 msoc_clk,
   input  logic                 rstn,
   input  uart_pkg::baud_t      baud_i,
   input  logic                 rx_i,
   output logic                 push_o,
   output uart_pkg::rx_entry_t  entry_o
);

   uart_pkg::urx_state_t state_q;
   logic [2:0]           samp_q;       // first two stages also synchronize
   logic                 maj;
   logic                 maj_prev_q;
   uart_pkg::baud_t      cnt;
   logic [2:0]           bit_cnt;
   uart_pkg::byte_t      shreg;
   logic                 cnt_zero;

   assign maj = (samp_q[0] & samp_q[1]) | (samp_q[1] & samp_q[2]) |
                (samp_q[0] & samp_q[2]);
   assign cnt_zero = (cnt == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         samp_q     <= 3'b111;
         maj_prev_q <= 1'b1;
         state_q    <= uart_pkg::URX_IDLE;
         cnt        <= '0;
         bit_cnt    <= '0;
         push_o     <= 1'b0;
      end
      else
      begin
         samp_q     <= {samp_q[1:0], rx_i};
         maj_prev_q <= maj;
         push_o     <= 1'b0;
         case (state_q)
            uart_pkg::URX_IDLE:
            begin
               if (maj_prev_q && !maj)
               begin
                  state_q <= uart_pkg::URX_START;
                  cnt     <= (baud_i >> 1) - 16'd1;      // half a bit
               end
            end
            uart_pkg::URX_START:
            begin
               if (!cnt_zero)
               begin
                  cnt <= cnt - 16'd1;
               end
               else if (!maj)
               begin
                  state_q <= uart_pkg::URX_DATA;
                  cnt     <= baud_i - 16'd1;
                  bit_cnt <= '0;
               end
               else
               begin
                  state_q <= uart_pkg::URX_IDLE;      // glitch, not a start bit
               end
            end
            uart_pkg::URX_DATA:
            begin
               if (!cnt_zero)
               begin
                  cnt <= cnt - 16'd1;
               end
               else
               begin
                  cnt     <= baud_i - 16'd1;
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7)
                  begin
                     state_q <= uart_pkg::URX_STOP;
                  end
               end
            end
            uart_pkg::URX_STOP:
            begin
               if (!cnt_zero)
               begin
                  cnt <= cnt - 16'd1;
               end
               else
               begin
                  push_o  <= 1'b1;      // at stop bit centre
                  state_q <= uart_pkg::URX_IDLE;
               end
            end
            default: state_q <= uart_pkg::URX_IDLE;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if ((state_q == uart_pkg::URX_DATA) && cnt_zero)
      begin
         shreg <= {maj, shreg[7:1]};      // lsb arrives first
      end
      if ((state_q == uart_pkg::URX_STOP) && cnt_zero)
      begin
         entry_o <= {~maj, shreg};        // low stop bit is a framing error
      end
   end

endmodule

// ==== design/uart_periph.sv ====
`timescale 1ns/1ps

module uart_periph
(
   input  logic                msoc_clk,
   input  logic                rstn,
   input  uart_pkg::bus_req_t  bus_i,
   input  logic                uart_rx_i,
   output logic [31:0]         rdata_o,
   output logic                uart_tx_o,
   output logic                uart_irq_o
);

   logic                tx_push;
   logic                tx_pop;
   logic                tx_full;
   logic                tx_empty;
   uart_pkg::byte_t     tx_byte;
   uart_pkg::byte_t     tx_head;
   logic                rx_push;
   logic                rx_pop;
   logic                rx_full;
   logic                rx_empty;
   uart_pkg::rx_entry_t rx_entry;
   uart_pkg::rx_entry_t rx_head;
   uart_pkg::baud_t     baud;

   assign uart_irq_o = ~rx_empty;      // data waiting

   uart_regs regs (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .bus_i     (bus_i),
      .rx_head_i (rx_head),
      .rx_empty_i(rx_empty),
      .rx_full_i (rx_full),
      .tx_full_i (tx_full),
      .rdata_o   (rdata_o),
      .tx_push_o (tx_push),
      .tx_byte_o (tx_byte),
      .rx_pop_o  (rx_pop),
      .baud_o    (baud)
   );

   uart_fifo #(.WIDTH($bits(uart_pkg::byte_t))) tx_fifo (
      .msoc_clk(msoc_clk),
      .rstn    (rstn),
      .push_i  (tx_push),
      .data_i  (tx_byte),
      .pop_i   (tx_pop),
      .data_o  (tx_head),
      .full_o  (tx_full),
      .empty_o (tx_empty)
   );

   uart_fifo #(.WIDTH($bits(uart_pkg::rx_entry_t))) rx_fifo (
      .msoc_clk(msoc_clk),
      .rstn    (rstn),
      .push_i  (rx_push),
      .data_i  (rx_entry),
      .pop_i   (rx_pop),
      .data_o  (rx_head),
      .full_o  (rx_full),
      .empty_o (rx_empty)
   );

   uart_tx_engine tx_engine (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .baud_i      (baud),
      .fifo_empty_i(tx_empty),
      .fifo_data_i (tx_head),
      .fifo_pop_o  (tx_pop),
      .tx_o        (uart_tx_o)
   );

   uart_rx_engine rx_engine (
      .msoc_clk(msoc_clk),
      .rstn    (rstn),
      .baud_i  (baud),
      .rx_i    (uart_rx_i),
      .push_o  (rx_push),
      .entry_o (rx_entry)
   );

endmodule

// ==== verification/uart_periph_tb.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_periph_tb;

   localparam int CLK_NS    = 8;
   localparam int NUM_TESTS = 8;
   localparam int DEPTH     = `UART_FIFO_DEPTH;
   // twelve frames per test at the slowest baud, with slack on top
   localparam int WATCHDOG_NS = NUM_TESTS * 12 * 10 * `UART_BAUD_DEFAULT * CLK_NS + 20000;

   typedef enum logic [1:0] {OP_RESET, OP_BAUD, OP_TX, OP_RX} op_t;

   typedef struct packed {
      op_t        op;
      logic [7:0] arg;            // new baud, or bytes sent
      logic       bad_stop;
      logic [7:0] exp_val;        // baud read back, or bytes that get through
   } test_t;

   logic               msoc_clk;
   logic               rstn;
   uart_pkg::bus_req_t bus;
   logic               rx_line;
   logic [31:0]        rdata;
   logic               tx_line;
   logic               irq;
   test_t              tests [NUM_TESTS];
   logic [31:0]        rng_state = 32'd88680;
   int                 cur_baud  = `UART_BAUD_DEFAULT;
   int                 errors    = 0;
   int                 pass_count = 0;
   int                 fail_count = 0;

   initial msoc_clk = 1'b0;
   always #(CLK_NS / 2) msoc_clk = ~msoc_clk;

   uart_periph uut (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .bus_i     (bus),
      .uart_rx_i (rx_line),
      .rdata_o   (rdata),
      .uart_tx_o (tx_line),
      .uart_irq_o(irq)
   );

   function automatic logic [7:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x[7:0];
   endfunction

   function automatic string op_name(input op_t op);
      case (op)
         OP_RESET: return "reset state";
         OP_BAUD:  return "baud register";
         OP_TX:    return "transmit";
         default:  return "receive";
      endcase
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected)
      begin
         $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
         errors++;
      end
   endtask

   task automatic bus_write(input int addr, input logic [31:0] data);
      @(posedge msoc_clk);
      bus <= '{en: 1'b1, we: 1'b1, addr: uart_pkg::reg_addr_t'(addr), wdata: data};
      @(posedge msoc_clk);
      bus <= '0;
   endtask

   task automatic bus_read(input int addr, output logic [31:0] data);
      @(posedge msoc_clk);
      bus <= '{en: 1'b1, we: 1'b0, addr: uart_pkg::reg_addr_t'(addr), wdata: 32'd0};
      @(posedge msoc_clk);
      bus <= '0;
      @(negedge msoc_clk);                 // read word registered on that edge
      data = rdata;
   endtask

   task automatic wait_irq_high(input int limit);
      int waited;
      waited = 0;
      while ((irq !== 1'b1) && (waited < limit))
      begin
         @(negedge msoc_clk);
         waited++;
      end
      if (irq !== 1'b1)
      begin
         $display("error at %0t: uart_irq_o did not rise after a received frame", $time);
         errors++;
      end
   endtask

   // samples the tx line at bit centres
   task automatic recv_tx_frame(output logic [7:0] data);
      int waited;
      int b;
      waited = 0;
      data   = 8'h00;
      @(negedge msoc_clk);
      while ((tx_line !== 1'b0) && (waited < 20 * cur_baud))
      begin
         @(negedge msoc_clk);
         waited++;
      end
      if (tx_line !== 1'b0)
      begin
         $display("error at %0t: no start bit appeared on the tx line", $time);
         errors++;
      end
      else
      begin
         repeat (cur_baud / 2) @(negedge msoc_clk);
         check({31'd0, tx_line}, 32'd0, "tx start bit");
         for (b = 0; b < 8; b++)
         begin
            repeat (cur_baud) @(negedge msoc_clk);
            data[b] = tx_line;                // lsb first
         end
         repeat (cur_baud) @(negedge msoc_clk);
         check({31'd0, tx_line}, 32'd1, "tx stop bit");
      end
   endtask

   task automatic drive_rx_frame(input logic [7:0] data, input logic bad_stop);
      logic [10:0] bits;
      int          b;
      bits = {1'b1, ~bad_stop, data, 1'b0};      // idle bit after the stop bit
      for (b = 0; b < 11; b++)
      begin
         @(posedge msoc_clk);
         rx_line <= bits[b];
         repeat (cur_baud - 1) @(posedge msoc_clk);
      end
   endtask

   task automatic run_reset_check(input logic [7:0] exp_baud);
      logic [31:0] word;
      bus_read(`UART_REG_BAUD, word);
      check(word, {24'd0, exp_baud}, "baud after reset");
      bus_read(`UART_REG_TX, word);
      check(word & 32'hE00, 32'h200, "status flags after reset");      // rx_empty only
      check({31'd0, irq}, 32'd0, "irq after reset");
      check({31'd0, tx_line}, 32'd1, "tx line after reset");
   endtask

   task automatic run_baud(input logic [7:0] baud, input logic [7:0] exp_baud);
      logic [31:0] word;
      bus_write(`UART_REG_BAUD, {24'd0, baud});
      bus_read(`UART_REG_BAUD, word);
      check(word, {24'd0, exp_baud}, "baud read back");
      cur_baud = baud;
   endtask

   task automatic run_tx(input int count, input int exp_frames);
      logic [7:0]  q [$];
      logic [31:0] word;
      logic [7:0]  got;
      logic        saw_low;
      int          i;
      int          j;
      for (i = 0; i < count; i++)
      begin
         q.push_back(next_random());
      end
      fork
         begin
            for (i = 0; i < count; i++)
            begin
               bus_write(`UART_REG_TX, {24'd0, q[i]});
            end
            bus_read(`UART_REG_TX, word);
            // first byte is already in the shifter
            check({31'd0, word[10]}, {31'd0, (count - 1 >= DEPTH)}, "tx_full after writes");
         end
         begin
            for (j = 0; j < exp_frames; j++)
            begin
               recv_tx_frame(got);
               check({24'd0, got}, {24'd0, q[j]}, "transmitted byte");
            end
         end
      join
      saw_low = 1'b0;
      repeat (20 * cur_baud)
      begin
         @(negedge msoc_clk);
         if (tx_line !== 1'b1)
         begin
            saw_low = 1'b1;
         end
      end
      check({31'd0, saw_low}, 32'd0, "tx line quiet after the last frame");
   endtask

   task automatic run_rx(input int count, input logic bad_stop, input int exp_stored);
      logic [7:0]  q [$];
      logic [31:0] word;
      logic [31:0] expected;
      int          i;
      for (i = 0; i < count; i++)
      begin
         q.push_back(next_random());
         drive_rx_frame(q[i], bad_stop);
      end
      wait_irq_high(2 * cur_baud);
      for (i = 0; i < exp_stored; i++)
      begin
         bus_read(`UART_REG_TX, word);
         // rx_full, tx_full, rx_empty, error bit, byte
         expected = {20'd0, (exp_stored - i == DEPTH), 1'b0, 1'b0, bad_stop, q[i]};
         check(word, expected, "rx status and head");
         bus_write(`UART_REG_RX_POP, 32'd0);
      end
      bus_read(`UART_REG_TX, word);
      check(word & 32'hE00, 32'h200, "rx FIFO empty after pops");
      check({31'd0, irq}, 32'd0, "irq after the last pop");
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the run was still going after %0d ns", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      int t;
      int errors_before;
      rstn    = 1'b0;
      bus     = '0;
      rx_line = 1'b1;
      tests[0] = '{OP_RESET, 8'd0, 1'b0, 8'd54};
      tests[1] = '{OP_BAUD, 8'd8, 1'b0, 8'd8};
      tests[2] = '{OP_TX, 8'd1, 1'b0, 8'd1};
      tests[3] = '{OP_TX, 8'd3, 1'b0, 8'd3};
      tests[4] = '{OP_RX, 8'd1, 1'b0, 8'd1};
      tests[5] = '{OP_RX, 8'd1, 1'b1, 8'd1};
      tests[6] = '{OP_RX, 8'd17, 1'b0, 8'd16};      // 17th frame dropped
      tests[7] = '{OP_TX, 8'd17, 1'b0, 8'd17};      // one in flight plus a full FIFO
      repeat (8) @(posedge msoc_clk);
      rstn <= 1'b1;
      for (t = 0; t < NUM_TESTS; t++)
      begin
         errors_before = errors;
         case (tests[t].op)
            OP_RESET: run_reset_check(tests[t].exp_val);
            OP_BAUD:  run_baud(tests[t].arg, tests[t].exp_val);
            OP_TX:    run_tx(tests[t].arg, tests[t].exp_val);
            default:  run_rx(tests[t].arg, tests[t].bad_stop, tests[t].exp_val);
         endcase
         if (errors == errors_before)
         begin
            pass_count++;
            $display("test %0d %s: passed", t, op_name(tests[t].op));
         end
         else
         begin
            fail_count++;
            $display("test %0d %s: failed", t, op_name(tests[t].op));
         end
      end
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (errors == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
design/uart_pkg.sv
design/uart_regs.sv
design/uart_fifo.sv
design/uart_tx_engine.sv
design/uart_rx_engine.sv
design/uart_periph.sv
verification/uart_periph_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module uart_periph_tb -f vlog.f -o uart_sim

out=$(./obj_dir/uart_sim)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1
